//--- tb.f
soc_reset_pkg.sv
sys_reset_seq.sv
ram_reset_timer.sv
board_status_ctrl.sv
board_ctrl_top.sv
tb_clkgen.sv
tb_board_ctrl.sv

//--- tb_board_ctrl.sv
// Testbench for the board reset and status top level.
// Directed reset sequences followed by sparse random requests, all
// checked every cycle against a cycle-accurate reference model.

module tb_board_ctrl;

	import soc_reset_pkg::*;

	localparam int unsigned CLK_PERIOD      = 8;
	localparam int unsigned CNTR_BITSZ      = 6;
	localparam int unsigned CNTR_MAX        = (1 << CNTR_BITSZ) - 1;
	localparam int unsigned RESET_CYCLES    = 10;
	localparam int unsigned MEASURE_LIMIT   = 2 * (1 << CNTR_BITSZ);
	localparam int unsigned RAND_CYCLES     = 2500;
	localparam int unsigned DIRECTED_CYCLES = 800;
	localparam int unsigned STIM_CYCLES     = RAND_CYCLES + DIRECTED_CYCLES;
	localparam longint unsigned WATCHDOG_TIME =
		(STIM_CYCLES + 4 * (1 << CNTR_BITSZ)) * CLK_PERIOD;
	localparam logic [31:0] SEED = 32'hf1ea_cabe;

	// Both SD lines high and no init error means no activity
	localparam pad_status_t PADS_IDLE = pad_status_t'(3'b110);

	logic                  clk200mhz_w;
	logic                  rst_p;
	rst_req_t              rst_req_i;
	logic                  pll_locked_i;
	logic                  dram_pll_locked_i;
	pad_status_t           pads_i;
	logic [GPIO_COUNT-1:0] gpio_i;
	board_rst_t            rst_o;
	logic                  ram_rst_o;
	logic [GPIO_COUNT-1:0] gp_o;

	// Reference model state preset to the values after the first reset edge
	logic [CNTR_BITSZ-1:0]    m_sys_cntr = '1;
	logic                     m_pwroff   = 1'b0;
	logic [CNTR_BITSZ-1:0]    m_ram_cntr = '1;
	logic                     m_act      = 1'b0;
	logic [ACT_DIM_BITSZ-1:0] m_act_cntr = '0;
	bit                       model_on   = 1'b0;

	int num_checks  = 0;
	int rst_errs    = 0;
	int gpio_errs   = 0;
	int bit_errs    = 0;
	int timing_errs = 0;

	tb_clkgen #(
		.PERIOD (CLK_PERIOD)
	) clkgen_i (
		.clk_o (clk200mhz_w)
	);

	board_ctrl_top #(
		.RST_CNTR_BITSZ (CNTR_BITSZ)
	) dut_i (
		 .clk200mhz_w       (clk200mhz_w)
		,.rst_p             (rst_p)
		,.rst_req_i         (rst_req_i)
		,.pll_locked_i      (pll_locked_i)
		,.dram_pll_locked_i (dram_pll_locked_i)
		,.pads_i            (pads_i)
		,.gpio_i            (gpio_i)
		,.rst_o             (rst_o)
		,.ram_rst_o         (ram_rst_o)
		,.gp_o              (gp_o)
	);

	task automatic check_rst(input board_rst_t got, input board_rst_t exp);
		num_checks++;
		if (got !== exp) begin
			rst_errs++;
			$display("** Error at %0t: rst_o is %b, expected %b (sys pu uart sd cache)",
				$time, got, exp);
		end
	endtask

	task automatic check_gpio(input logic [GPIO_COUNT-1:0] got,
			input logic [GPIO_COUNT-1:0] exp);
		num_checks++;
		if (got !== exp) begin
			gpio_errs++;
			$display("** Error at %0t: gp_o is %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		num_checks++;
		if (got !== exp) begin
			bit_errs++;
			$display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Expected reset fan-out from model state and current inputs
	function automatic board_rst_t model_rst();
		board_rst_t r;
		logic       sys;
		sys         = (m_sys_cntr != '0) || m_pwroff || !pll_locked_i;
		r.sys_rst   = sys;
		r.pu_rst    = sys || !dram_pll_locked_i;
		r.uart_rst  = rst_p || !pll_locked_i;
		r.sd_reset  = sys;
		r.cache_rst = (m_ram_cntr != '0) || rst_req_i.cache_rst_req;
		return r;
	endfunction

	// Next model state from the inputs the coming rising edge samples
	task automatic advance_model();
		sw_rst_e cmd;
		logic    restart;
		logic    act_evt;
		cmd     = sw_rst_e'({rst_req_i.sw_rst1, rst_req_i.sw_rst0});
		restart = rst_p || rst_req_i.pu_rst_req || (cmd == SWRST_WARM);
		act_evt = !(pads_i.sd_di && pads_i.sd_do) || pads_i.dram_init_error;

		if (restart)
			m_sys_cntr = '1;
		else if (m_sys_cntr != '0)
			m_sys_cntr = m_sys_cntr - 1'b1;

		if (cmd == SWRST_PWROFF)
			m_pwroff = 1'b1;
		else if (rst_p)
			m_pwroff = 1'b0;

		if (rst_p)
			m_ram_cntr = '1;
		else if (pll_locked_i && (m_ram_cntr != '0))
			m_ram_cntr = m_ram_cntr - 1'b1;

		if (rst_p) begin
			m_act      = 1'b0;
			m_act_cntr = '0;
		end else if (m_act_cntr != '0) begin
			m_act      = 1'b0;
			m_act_cntr = m_act_cntr - 1'b1;
		end else if (act_evt) begin
			m_act      = 1'b1;
			m_act_cntr = '1;
		end
	endtask

	// Outputs are settled at the falling edge
	always @(negedge clk200mhz_w) begin
		if (model_on) begin
			check_rst(rst_o, model_rst());
			check_gpio(gp_o, gpio_i | {{(GPIO_COUNT-1){1'b0}}, m_act});
			check_bit(ram_rst_o, m_ram_cntr != '0, "ram_rst_o");
			advance_model();
		end
	end

	// Raise or drop one kind of request on a rising edge
	task automatic drive_event(input int kind, input logic on);
		case (kind)
			0: rst_req_i.pu_rst_req <= on;
			1: rst_req_i.sw_rst1 <= on;
			2: rst_req_i.sw_rst0 <= on;
			3: begin
				rst_req_i.sw_rst1 <= on;
				rst_req_i.sw_rst0 <= on;
			end
			4: rst_req_i.cache_rst_req <= on;
			5: rst_p <= on;
			6: pll_locked_i <= !on;
			default: dram_pll_locked_i <= !on;
		endcase
	endtask

	// Hold a request for the given number of sampled edges
	task automatic pulse_request(input int kind, input int cycles);
		@(posedge clk200mhz_w);
		drive_event(kind, 1'b1);
		repeat (cycles) @(posedge clk200mhz_w);
		drive_event(kind, 1'b0);
	endtask

	// Count edges from the last restart edge until sys_rst drops
	task automatic measure_release(input string what);
		int edges;
		bit fell;
		edges = 0;
		fell  = 1'b0;
		while (!fell && edges < MEASURE_LIMIT) begin
			@(posedge clk200mhz_w);
			edges++;
			@(negedge clk200mhz_w);
			fell = !rst_o.sys_rst;
		end
		if (!fell) begin
			timing_errs++;
			$display("After the %s, sys_rst never fell within %0d edges",
				what, MEASURE_LIMIT);
		end else if (edges != CNTR_MAX) begin
			timing_errs++;
			$display("** Error at %0t: sys_rst fell %0d edges after the %s, expected %0d",
				$time, edges, what, CNTR_MAX);
		end
	endtask

	// Sparse requests with random hold times so the counters can expire
	task automatic run_random(input int cycles);
		int kind;
		int hold_cnt;
		kind     = 0;
		hold_cnt = 0;
		for (int cyc = 0; cyc < cycles; cyc++) begin
			@(posedge clk200mhz_w);
			gpio_i <= GPIO_COUNT'($urandom);
			if ($urandom_range(0, 3) == 0)
				pads_i <= pad_status_t'($urandom_range(0, 7));
			else
				pads_i <= PADS_IDLE;
			if (hold_cnt != 0) begin
				hold_cnt--;
				if (hold_cnt == 0)
					drive_event(kind, 1'b0);
			end else if ($urandom_range(0, 99) == 0) begin
				kind     = $urandom_range(0, 7);
				hold_cnt = $urandom_range(1, 4);
				drive_event(kind, 1'b1);
			end
		end
		@(posedge clk200mhz_w);
		drive_event(kind, 1'b0);
		pads_i <= PADS_IDLE;
	endtask

	initial begin
		int err_total;
		void'($urandom(SEED));
		rst_p             = 1'b1;
		rst_req_i         = '0;
		pll_locked_i      = 1'b1;
		dram_pll_locked_i = 1'b1;
		pads_i            = PADS_IDLE;
		gpio_i            = '0;

		// Board reset and then the full count with both clocks locked
		@(posedge clk200mhz_w);
		model_on = 1'b1;
		repeat (RESET_CYCLES - 1) @(posedge clk200mhz_w);
		rst_p <= 1'b0;
		measure_release("board reset");

		pulse_request(0, 3);
		measure_release("processor request");
		pulse_request(1, 3);
		measure_release("warm reset");

		// Cold code is decoded but ignored
		pulse_request(3, 3);
		repeat (4) @(posedge clk200mhz_w);
		@(negedge clk200mhz_w);
		check_bit(rst_o.sys_rst, 1'b0, "sys_rst after cold code");

		// Power-off outlasts the counter until the next board reset
		pulse_request(2, 1);
		repeat (2 * CNTR_MAX) @(posedge clk200mhz_w);
		@(negedge clk200mhz_w);
		check_bit(rst_o.sys_rst, 1'b1, "sys_rst during power-off");
		@(posedge clk200mhz_w);
		rst_p <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk200mhz_w);
		rst_p <= 1'b0;
		measure_release("reset after power-off");

		// RAM timer waits for lock and ignores a warm reset
		@(posedge clk200mhz_w);
		rst_p        <= 1'b1;
		pll_locked_i <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk200mhz_w);
		rst_p <= 1'b0;
		repeat (20) @(posedge clk200mhz_w);
		pll_locked_i <= 1'b1;
		repeat (20) @(posedge clk200mhz_w);
		pulse_request(1, 2);
		repeat (CNTR_MAX + 10) @(posedge clk200mhz_w);

		// Cache request alone drives cache_rst once the RAM timer expired
		pulse_request(4, 3);

		// Clock loss on either generator
		pulse_request(6, 4);
		repeat (8) @(posedge clk200mhz_w);
		pulse_request(7, 4);
		repeat (CNTR_MAX + 8) @(posedge clk200mhz_w);

		run_random(RAND_CYCLES);

		repeat (2) @(posedge clk200mhz_w);
		@(negedge clk200mhz_w);
		#1;
		err_total = rst_errs + gpio_errs + bit_errs + timing_errs;
		$display("Checks %0d, errors %0d: rst %0d, gpio %0d, ram_rst %0d, timing %0d",
			num_checks, err_total, rst_errs, gpio_errs, bit_errs, timing_errs);
		if (err_total == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// Watchdog sized from the stimulus length plus counter margin
	initial begin
		#(WATCHDOG_TIME);
		$display("Watchdog expired at %0t before the tests finished", $time);
		$display("TEST FAIL");
		$finish;
	end

endmodule

//--- tb_clkgen.sv
// Testbench clock source.
// Free-running clock with a configurable period, starting low.

module tb_clkgen #(
	parameter int unsigned PERIOD = 8
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD / 2) clk_o = ~clk_o;
		end
	end

endmodule

//--- board_ctrl_top.sv
// Board reset and status top level.
// Runs the system reset sequencer and the RAM reset timer side by side
// and feeds both into the board status controller.

module board_ctrl_top #(
	parameter int unsigned RST_CNTR_BITSZ = soc_reset_pkg::RST_CNTR_BITSZ_DEF
) (
	 input  logic                                 clk200mhz_w
	,input  logic                                 rst_p
	,input  soc_reset_pkg::rst_req_t              rst_req_i
	,input  logic                                 pll_locked_i
	,input  logic                                 dram_pll_locked_i
	,input  soc_reset_pkg::pad_status_t           pads_i
	,input  logic [soc_reset_pkg::GPIO_COUNT-1:0] gpio_i
	,output soc_reset_pkg::board_rst_t            rst_o
	,output logic                                 ram_rst_o
	,output logic [soc_reset_pkg::GPIO_COUNT-1:0] gp_o
);

	logic cntr_busy;
	logic pwroff;
	logic ram_rst;

	// Restartable system reset counter and power-off latch
	sys_reset_seq #(
		.RST_CNTR_BITSZ (RST_CNTR_BITSZ)
	) u_sys_reset_seq (
		 .clk200mhz_w (clk200mhz_w)
		,.rst_p       (rst_p)
		,.rst_req_i   (rst_req_i)
		,.cntr_busy_o (cntr_busy)
		,.pwroff_o    (pwroff)
	);

	// One-shot RAM reset after a global reset
	ram_reset_timer #(
		.RST_CNTR_BITSZ (RST_CNTR_BITSZ)
	) u_ram_reset_timer (
		 .clk200mhz_w  (clk200mhz_w)
		,.rst_p        (rst_p)
		,.pll_locked_i (pll_locked_i)
		,.ram_rst_o    (ram_rst)
	);

	// Reset fan-out and activity LED
	board_status_ctrl u_board_status_ctrl (
		 .clk200mhz_w       (clk200mhz_w)
		,.rst_p             (rst_p)
		,.cntr_busy_i       (cntr_busy)
		,.pwroff_i          (pwroff)
		,.ram_rst_i         (ram_rst)
		,.cache_rst_req_i   (rst_req_i.cache_rst_req)
		,.pll_locked_i      (pll_locked_i)
		,.dram_pll_locked_i (dram_pll_locked_i)
		,.pads_i            (pads_i)
		,.gpio_i            (gpio_i)
		,.rst_o             (rst_o)
		,.ram_rst_o         (ram_rst_o)
		,.gp_o              (gp_o)
	);

endmodule

//--- board_status_ctrl.sv
// Board status controller.
// Combines the system counter, the power-off latch, the RAM timer and
// the lock flags into the reset fan-out, and drives a dimmed activity
// pulse onto GPIO bit 0.

module board_status_ctrl (
	 input  logic                                      clk200mhz_w
	,input  logic                                      rst_p
	,input  logic                                      cntr_busy_i
	,input  logic                                      pwroff_i
	,input  logic                                      ram_rst_i
	,input  logic                                      cache_rst_req_i
	,input  logic                                      pll_locked_i
	,input  logic                                      dram_pll_locked_i
	,input  soc_reset_pkg::pad_status_t                pads_i
	,input  logic [soc_reset_pkg::GPIO_COUNT-1:0]      gpio_i
	,output soc_reset_pkg::board_rst_t                 rst_o
	,output logic                                      ram_rst_o
	,output logic [soc_reset_pkg::GPIO_COUNT-1:0]      gp_o
);

	import soc_reset_pkg::*;

	logic                     sys_rst;
	logic                     act_evt;
	logic                     act_q;
	logic [ACT_DIM_BITSZ-1:0] act_cntr_q;

	// System reset holds while counting, after power-off or without clocks
	assign sys_rst = cntr_busy_i || pwroff_i || !pll_locked_i;

	// Reset fan-out
	always_comb begin
		rst_o.sys_rst  = sys_rst;
		// Processors also wait for the DRAM clock
		rst_o.pu_rst   = sys_rst || !dram_pll_locked_i;
		// Buffered UART data survives software resets
		rst_o.uart_rst = rst_p || !pll_locked_i;
		rst_o.sd_reset = sys_rst;
		rst_o.cache_rst = ram_rst_i || cache_rst_req_i;
	end

	assign ram_rst_o = ram_rst_i;

	// Activity event
	// SD lines not both idle high, or DRAM init failed
	assign act_evt = !(pads_i.sd_di && pads_i.sd_do) || pads_i.dram_init_error;

	// Dimmed activity pulse
	// After each pulse the counter blanks the LED for its full range
	always_ff @(posedge clk200mhz_w) begin
		if (rst_p) begin
			act_q      <= 1'b0;
			act_cntr_q <= '0;
		end else if (act_cntr_q != '0) begin
			act_q      <= 1'b0;
			act_cntr_q <= act_cntr_q - 1'b1;
		end else if (act_evt) begin
			act_q      <= 1'b1;
			act_cntr_q <= '1;
		end
	end

	// Activity shares bit 0 with the GPIO block
	assign gp_o = gpio_i | {{(GPIO_COUNT-1){1'b0}}, act_q};

	// With a one-bit dimmer the LED is never lit on two edges in a row
	act_dim_a: assert property (
		@(posedge clk200mhz_w)
		act_q |=> !act_q
	) else $error("activity pulse high on consecutive edges");

endmodule

//--- ram_reset_timer.sv
// One-shot RAM reset timer.
// Keeps the RAM controller and its cache in reset for a fixed number
// of locked clock cycles after a global reset only, since the cache
// contents are preloaded only then.

module ram_reset_timer #(
	parameter int unsigned RST_CNTR_BITSZ = soc_reset_pkg::RST_CNTR_BITSZ_DEF
) (
	 input  logic clk200mhz_w
	,input  logic rst_p
	,input  logic pll_locked_i
	,output logic ram_rst_o
);

	logic [RST_CNTR_BITSZ-1:0] ram_cntr_q;

	// Count only while the clock generator is locked
	// Software resets never reach this counter
	always_ff @(posedge clk200mhz_w) begin
		if (rst_p) begin
			ram_cntr_q <= '1;
		end else if (pll_locked_i && (ram_cntr_q != '0)) begin
			ram_cntr_q <= ram_cntr_q - 1'b1;
		end
	end

	assign ram_rst_o = (ram_cntr_q != '0);

	// Outside the board reset the counter only moves down or holds
	ram_cntr_mono_a: assert property (
		@(posedge clk200mhz_w)
		!rst_p |=> (ram_cntr_q <= $past(ram_cntr_q))
	) else $error("RAM reset counter went up without a board reset");

endmodule

//--- sys_reset_seq.sv
// System reset sequencer.
// Runs a long reset counter restarted by the board button, the
// processor cluster or a software warm reset, decodes the device
// table reset bits and holds the software power-off latch.

module sys_reset_seq #(
	parameter int unsigned RST_CNTR_BITSZ = soc_reset_pkg::RST_CNTR_BITSZ_DEF
) (
	 input  logic                    clk200mhz_w
	,input  logic                    rst_p
	,input  soc_reset_pkg::rst_req_t rst_req_i
	,output logic                    cntr_busy_o
	,output logic                    pwroff_o
);

	import soc_reset_pkg::*;

	sw_rst_e                     sw_cmd;
	logic                        restart;
	logic [RST_CNTR_BITSZ-1:0]   rst_cntr_q;
	logic                        pwroff_q;

	// Decode the two device table bits into a command
	// The cold reset code is recognised but acts like no command here
	assign sw_cmd = sw_rst_e'({rst_req_i.sw_rst1, rst_req_i.sw_rst0});

	// Any of these restarts the full reset period
	assign restart = rst_p
		|| rst_req_i.pu_rst_req
		|| (sw_cmd == SWRST_WARM);

	// Reload on restart, otherwise count down and park at zero
	always_ff @(posedge clk200mhz_w) begin
		if (restart) begin
			rst_cntr_q <= '1;
		end else if (rst_cntr_q != '0) begin
			rst_cntr_q <= rst_cntr_q - 1'b1;
		end
	end

	// System stays in reset while the counter runs
	assign cntr_busy_o = (rst_cntr_q != '0);

	// Power-off latch
	// A power-off request beats the board button on the same edge
	always_ff @(posedge clk200mhz_w) begin
		if (sw_cmd == SWRST_PWROFF) begin
			pwroff_q <= 1'b1;
		end else if (rst_p) begin
			pwroff_q <= 1'b0;
		end
	end

	assign pwroff_o = pwroff_q;

	// Latch can only be set by a power-off command seen one edge earlier
	pwroff_rise_a: assert property (
		@(posedge clk200mhz_w)
		$rose(pwroff_o) |-> $past(sw_cmd == SWRST_PWROFF)
	) else $error("power-off latch set without a power-off command");

endmodule

//--- soc_reset_pkg.sv
// Shared definitions for the board reset and status logic.
// Holds the GPIO and counter widths, the software reset command
// encoding and the grouped request, reset and pad status signals.

package soc_reset_pkg;

	// Number of GPIO outputs on the board header
	localparam int unsigned GPIO_COUNT = 8;

	// Width of the activity dimming counter
	// One bit lights the LED on every other clock at most
	localparam int unsigned ACT_DIM_BITSZ = 1;

	// Default width of the system and RAM reset counters
	// 2^20 cycles at 200 MHz is a little over 5 ms
	localparam int unsigned RST_CNTR_BITSZ_DEF = 20;

	// Software reset command, encoded as {rst1, rst0} from the device table
	typedef enum logic [1:0] {
		SWRST_NONE   = 2'b00,
		SWRST_PWROFF = 2'b01,
		SWRST_WARM   = 2'b10,
		SWRST_COLD   = 2'b11
	} sw_rst_e;

	// Reset requests coming from the processor side
	typedef struct packed {
		// Processor cluster asks for a system reset
		logic pu_rst_req;
		// Device table reset bits
		logic sw_rst0;
		logic sw_rst1;
		// Device table asks for a RAM cache flush
		logic cache_rst_req;
	} rst_req_t;

	// Derived resets, all active high
	typedef struct packed {
		logic sys_rst;
		logic pu_rst;
		// Only the board button and clock loss reset the UART
		logic uart_rst;
		// SD card power control, low powers the card
		logic sd_reset;
		logic cache_rst;
	} board_rst_t;

	// Pad level signals watched by the activity LED
	typedef struct packed {
		logic sd_di;
		logic sd_do;
		logic dram_init_error;
	} pad_status_t;

endpackage
